// File: pmp_pkg.sv
`default_nettype none

package pmp_pkg;

    //////////////////////////////////////////////////////////////////////
    // PMP configuration view
    //////////////////////////////////////////////////////////////////////

    // pmpaddr holds physical address bits 33:2
    localparam int PMP_ADDR_W = 32;

    // Address matching mode, only TOR is decoded by the checker
    typedef enum logic [1:0] {
        PMP_OFF   = 2'b00,
        PMP_TOR   = 2'b01,
        PMP_NA4   = 2'b10,
        PMP_NAPOT = 2'b11
    } pmp_amode_e;

    // One pmpcfg byte
    typedef struct packed {
        logic       lock;
        logic [1:0] rsvd;
        pmp_amode_e mode;
        logic       x;
        logic       w;
        logic       r;
    } pmp_cfg_entry_t;

    // Written as a word, read back as four entries
    // Entry k sits in byte k
    typedef union packed {
        logic [31:0]               word;
        pmp_cfg_entry_t [3:0]      entry;
    } pmpcfg_word_u;

    // Checker view of all regions
    typedef struct packed {
        pmp_cfg_entry_t [15:0]          cfg;
        logic [15:0][PMP_ADDR_W-1:0]    addr;
    } pmp_csr_t;

endpackage

`default_nettype wire

// File: mmu_pmp_req_pkg.sv
`default_nettype none

package mmu_pmp_req_pkg;

    //////////////////////////////////////////////////////////////////////
    // Request and response traffic
    //////////////////////////////////////////////////////////////////////

    localparam int PADDR_W = 34;

    // 01 is not a checked access
    typedef enum logic [1:0] {
        ACC_FETCH = 2'b00,
        ACC_RSVD  = 2'b01,
        ACC_STORE = 2'b10,
        ACC_LOAD  = 2'b11
    } access_type_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } priv_mode_e;

    // Exception codes
    localparam logic [4:0] MCAUSE_NONE  = 5'd0;
    localparam logic [4:0] MCAUSE_FETCH = 5'd1;
    localparam logic [4:0] MCAUSE_LOAD  = 5'd5;
    localparam logic [4:0] MCAUSE_STORE = 5'd7;

    // 48 bits
    typedef struct packed {
        logic [3:0]         way;
        logic [5:0]         index;
        logic [PADDR_W-1:0] paddr;
        priv_mode_e         mode;
        access_type_e       acc;
    } pmp_req_t;

    // 51 bits
    typedef struct packed {
        logic [3:0]         way;
        logic [5:0]         index;
        logic [4:0]         mcause;
        access_type_e       acc;
        logic [PADDR_W-1:0] paddr;
    } pmp_resp_t;

endpackage

`default_nettype wire

// File: pmp_csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

module pmp_csr_regs
    import pmp_pkg::*;
#(
    parameter int N_REGIONS = 16
) (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        i_csr_we,
    input  wire logic [4:0]  i_csr_sel,
    input  wire logic [31:0] i_csr_wdata,
    output pmp_csr_t         o_csr
);

    localparam int         N_CFG_WORDS   = N_REGIONS / 4;
    localparam logic [4:0] ADDR_SEL_BASE = 5'd4;

    pmpcfg_word_u          cfg_q  [N_CFG_WORDS];
    logic [PMP_ADDR_W-1:0] addr_q [N_REGIONS];

    //////////////////////////////////////////////////////////////////////
    // Register writes
    //////////////////////////////////////////////////////////////////////

    // Selector 0..3 picks a pmpcfg word, 4..19 a pmpaddr
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < N_CFG_WORDS; i++) begin
                cfg_q[i] <= '0;
            end
            for (int i = 0; i < N_REGIONS; i++) begin
                addr_q[i] <= '0;
            end
        end else if (i_csr_we) begin
            for (int i = 0; i < N_CFG_WORDS; i++) begin
                if (i_csr_sel == 5'(i)) begin
                    cfg_q[i].word <= i_csr_wdata;
                end
            end
            for (int i = 0; i < N_REGIONS; i++) begin
                if (i_csr_sel == ADDR_SEL_BASE + 5'(i)) begin
                    addr_q[i] <= i_csr_wdata;
                end
            end
        end
    end

    // Unpack each word into per-region entries
    always_comb begin
        o_csr = '0;
        for (int k = 0; k < N_REGIONS; k++) begin
            o_csr.cfg[k]  = cfg_q[k / 4].entry[k % 4];
            o_csr.addr[k] = addr_q[k];
        end
    end

endmodule

`default_nettype wire

// File: pmp_region_match.sv
`timescale 1ns/1ps
`default_nettype none

module pmp_region_match
    import pmp_pkg::*;
    import mmu_pmp_req_pkg::*;
#(
    parameter int N_REGIONS = 16
) (
    input  wire logic [PADDR_W-1:0]   i_paddr,
    input  wire pmp_csr_t             i_csr,
    output logic [N_REGIONS-1:0]      o_hit
);

    // Word address compared against pmpaddr
    logic [PMP_ADDR_W-1:0] addr_word;

    assign addr_word = i_paddr[PADDR_W-1:2];

    // TOR window is [pmpaddr[k-1], pmpaddr[k])
    for (genvar k = 0; k < N_REGIONS; k++) begin : g_region
        logic [PMP_ADDR_W-1:0] bottom;

        if (k == 0) begin : g_base
            assign bottom = '0;
        end else begin : g_prev
            assign bottom = i_csr.addr[k-1];
        end

        assign o_hit[k] = (i_csr.cfg[k].mode == PMP_TOR)
                        && (addr_word >= bottom)
                        && (addr_word < i_csr.addr[k]);
    end

endmodule

`default_nettype wire

// File: mmu_pmp_match_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_pmp_match_stage
    import pmp_pkg::*;
    import mmu_pmp_req_pkg::*;
#(
    parameter int N_REGIONS = 16
) (
    input  wire logic                 clk,
    input  wire logic                 rstn,
    // Request side
    input  wire logic                 i_req_drive,
    output logic                      o_req_free,
    input  wire pmp_req_t             i_req,
    // Live CSR view
    input  wire pmp_csr_t             i_csr,
    // Towards check stage
    output logic                      o_drive,
    input  wire logic                 i_free,
    output pmp_req_t                  o_req,
    output logic [N_REGIONS-1:0]      o_hit
);

    logic     valid_q;
    pmp_req_t req_q;

    // Room when empty or the held item leaves this edge
    assign o_req_free = !valid_q || i_free;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (o_req_free) begin
            valid_q <= i_req_drive;
        end
    end

    always_ff @(posedge clk) begin
        if (i_req_drive && o_req_free) begin
            req_q <= i_req;
        end
    end

    assign o_drive = valid_q;
    assign o_req   = req_q;

    pmp_region_match #(
        .N_REGIONS (N_REGIONS)
    ) region_match_i (
        .i_paddr (req_q.paddr),
        .i_csr   (i_csr),
        .o_hit   (o_hit)
    );

endmodule

`default_nettype wire

// File: mmu_pmp_check_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_pmp_check_stage
    import pmp_pkg::*;
    import mmu_pmp_req_pkg::*;
#(
    parameter int N_REGIONS = 16
) (
    input  wire logic                 clk,
    input  wire logic                 rstn,
    // From match stage
    input  wire logic                 i_drive,
    output logic                      o_free,
    input  wire pmp_req_t             i_req,
    input  wire [N_REGIONS-1:0]       i_hit,
    input  wire pmp_csr_t             i_csr,
    // Response side
    output logic                      o_resp_drive,
    input  wire logic                 i_resp_free,
    output pmp_resp_t                 o_resp
);

    logic           valid_q;
    pmp_req_t       req_q;
    pmp_cfg_entry_t entry_q;
    pmp_cfg_entry_t entry_sel;
    logic           checked;
    logic [4:0]     mcause;

    //////////////////////////////////////////////////////////////////////
    // Priority select and capture
    //////////////////////////////////////////////////////////////////////

    // Lowest index wins, no hit leaves no permissions
    always_comb begin
        entry_sel = '0;
        for (int k = N_REGIONS - 1; k >= 0; k--) begin
            if (i_hit[k]) begin
                entry_sel = i_csr.cfg[k];
            end
        end
    end

    assign o_free = !valid_q || i_resp_free;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (o_free) begin
            valid_q <= i_drive;
        end
    end

    always_ff @(posedge clk) begin
        if (i_drive && o_free) begin
            req_q   <= i_req;
            entry_q <= entry_sel;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Permission check
    //////////////////////////////////////////////////////////////////////

    // M mode is only bound by locked entries
    assign checked = entry_q.lock || (req_q.mode != PRIV_M);

    always_comb begin
        mcause = MCAUSE_NONE;
        if (checked) begin
            case (req_q.acc)
                ACC_FETCH: if (!entry_q.x) mcause = MCAUSE_FETCH;
                ACC_STORE: if (!entry_q.w) mcause = MCAUSE_STORE;
                ACC_LOAD:  if (!entry_q.r) mcause = MCAUSE_LOAD;
                default:   mcause = MCAUSE_NONE;
            endcase
        end
    end

    assign o_resp_drive  = valid_q;
    assign o_resp.way    = req_q.way;
    assign o_resp.index  = req_q.index;
    assign o_resp.mcause = mcause;
    assign o_resp.acc    = req_q.acc;
    assign o_resp.paddr  = req_q.paddr;

endmodule

`default_nettype wire

// File: mmu_pmp_top.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_pmp_top
    import pmp_pkg::*;
    import mmu_pmp_req_pkg::*;
#(
    parameter int N_REGIONS = 16
) (
    input  wire logic        clk,
    input  wire logic        rstn,
    // Request side
    input  wire logic        i_req_drive,
    output logic             o_req_free,
    input  wire pmp_req_t    i_req,
    // Response side
    output logic             o_resp_drive,
    input  wire logic        i_resp_free,
    output pmp_resp_t        o_resp,
    // CSR write port
    input  wire logic        i_csr_we,
    input  wire logic [4:0]  i_csr_sel,
    input  wire logic [31:0] i_csr_wdata
);

    pmp_csr_t             csr;
    logic                 mid_drive;
    logic                 mid_free;
    pmp_req_t             mid_req;
    logic [N_REGIONS-1:0] mid_hit;

    pmp_csr_regs #(
        .N_REGIONS (N_REGIONS)
    ) csr_regs_i (
        .clk         (clk),
        .rstn        (rstn),
        .i_csr_we    (i_csr_we),
        .i_csr_sel   (i_csr_sel),
        .i_csr_wdata (i_csr_wdata),
        .o_csr       (csr)
    );

    mmu_pmp_match_stage #(
        .N_REGIONS (N_REGIONS)
    ) match_stage_i (
        .clk         (clk),
        .rstn        (rstn),
        .i_req_drive (i_req_drive),
        .o_req_free  (o_req_free),
        .i_req       (i_req),
        .i_csr       (csr),
        .o_drive     (mid_drive),
        .i_free      (mid_free),
        .o_req       (mid_req),
        .o_hit       (mid_hit)
    );

    mmu_pmp_check_stage #(
        .N_REGIONS (N_REGIONS)
    ) check_stage_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_drive      (mid_drive),
        .o_free       (mid_free),
        .i_req        (mid_req),
        .i_hit        (mid_hit),
        .i_csr        (csr),
        .o_resp_drive (o_resp_drive),
        .i_resp_free  (i_resp_free),
        .o_resp       (o_resp)
    );

endmodule

`default_nettype wire

// File: mmu_pmp_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_pmp_properties
    import mmu_pmp_req_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rstn,
    input  wire logic      i_resp_drive,
    input  wire logic      i_resp_free,
    input  wire pmp_resp_t i_resp
);

    int unsigned fail_count = 0;

    // Reset empties the response slot
    resp_idle_in_reset: assert property (@(posedge clk) !rstn |=> !i_resp_drive)
        else begin
            $error("o_resp_drive high after a reset edge");
            fail_count++;
        end

    // Held response under back-pressure
    resp_held: assert property (@(posedge clk) disable iff (!rstn)
        i_resp_drive && !i_resp_free |=> i_resp_drive && $stable(i_resp))
        else begin
            $error("o_resp or o_resp_drive changed while stalled");
            fail_count++;
        end

    mcause_legal: assert property (@(posedge clk) disable iff (!rstn)
        i_resp_drive |-> i_resp.mcause inside {5'd0, 5'd1, 5'd5, 5'd7})
        else begin
            $error("illegal mcause %0d", i_resp.mcause);
            fail_count++;
        end

endmodule

bind mmu_pmp_top mmu_pmp_properties props_i (
    .clk          (clk),
    .rstn         (rstn),
    .i_resp_drive (o_resp_drive),
    .i_resp_free  (i_resp_free),
    .i_resp       (o_resp)
);

`default_nettype wire

// File: tb_mmu_pmp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mmu_pmp
    import pmp_pkg::*;
    import mmu_pmp_req_pkg::*;
();

    localparam int N_REGIONS = 16;

    logic        clk;
    logic        rstn;
    logic        i_req_drive;
    logic        o_req_free;
    pmp_req_t    i_req;
    logic        o_resp_drive;
    logic        i_resp_free;
    pmp_resp_t   o_resp;
    logic        i_csr_we;
    logic [4:0]  i_csr_sel;
    logic [31:0] i_csr_wdata;

    // Model state
    pmp_cfg_entry_t cfg_m  [N_REGIONS];
    logic [31:0]    addr_m [N_REGIONS];
    pmp_req_t       stim_q [$];
    pmp_resp_t      exp_q  [$];
    int             acc_q  [$];
    logic [31:0]    rng_state = 32'h9f2a;
    bit             hold_free = 1'b0;
    int             cycle = 0;

    mmu_pmp_top #(
        .N_REGIONS (N_REGIONS)
    ) dut_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_req_drive  (i_req_drive),
        .o_req_free   (o_req_free),
        .i_req        (i_req),
        .o_resp_drive (o_resp_drive),
        .i_resp_free  (i_resp_free),
        .o_resp       (o_resp),
        .i_csr_we     (i_csr_we),
        .i_csr_sel    (i_csr_sel),
        .i_csr_wdata  (i_csr_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // First TOR region holding the word wins, no hit means no permissions
    function automatic logic [4:0] expect_mcause(pmp_req_t r);
        pmp_cfg_entry_t e;
        logic [31:0]    lo;
        logic           found;
        e = '0;
        found = 1'b0;
        for (int k = 0; k < N_REGIONS; k++) begin
            lo = (k == 0) ? 32'd0 : addr_m[k-1];
            if (!found && cfg_m[k].mode == PMP_TOR && r.paddr[33:2] >= lo
                    && r.paddr[33:2] < addr_m[k]) begin
                e = cfg_m[k];
                found = 1'b1;
            end
        end
        if (!e.lock && r.mode == PRIV_M) return 5'd0;
        if (r.acc == ACC_FETCH && !e.x) return 5'd1;
        if (r.acc == ACC_STORE && !e.w) return 5'd7;
        if (r.acc == ACC_LOAD && !e.r) return 5'd5;
        return 5'd0;
    endfunction

    function automatic pmp_resp_t expect_resp(pmp_req_t r);
        pmp_resp_t e;
        e.way    = r.way;
        e.index  = r.index;
        e.acc    = r.acc;
        e.paddr  = r.paddr;
        e.mcause = expect_mcause(r);
        return e;
    endfunction

    function automatic pmp_req_t make_req(priv_mode_e m, logic [1:0] a, logic [31:0] word);
        pmp_req_t    r;
        logic [31:0] v;
        v = next_rand();
        r.way   = v[3:0];
        r.index = v[9:4];
        r.mode  = m;
        r.acc   = access_type_e'(a);
        r.paddr = {word, v[11:10]};
        return r;
    endfunction

    function automatic pmp_req_t random_req();
        logic [31:0] v;
        priv_mode_e  m;
        v = next_rand();
        case (v[1:0])
            2'd0:    m = PRIV_U;
            2'd1:    m = PRIV_S;
            default: m = PRIV_M;
        endcase
        return make_req(m, v[3:2], next_rand() % (addr_m[N_REGIONS-1] + 32'h40));
    endfunction

    task automatic write_csr(input logic [4:0] sel, input logic [31:0] data);
        @(negedge clk);
        i_csr_we    = 1'b1;
        i_csr_sel   = sel;
        i_csr_wdata = data;
        if (sel < 5'd4) begin
            for (int b = 0; b < 4; b++) begin
                cfg_m[sel*4 + b] = pmp_cfg_entry_t'(data[8*b +: 8]);
            end
        end else begin
            addr_m[sel - 5'd4] = data;
        end
        @(negedge clk);
        i_csr_we = 1'b0;
    endtask

    // Mostly TOR entries over a mostly ascending address map
    task automatic write_random_csrs();
        logic [31:0] data;
        logic [31:0] mask;
        logic [31:0] top;
        logic [31:0] step;
        top = '0;
        for (int w = 0; w < N_REGIONS / 4; w++) begin
            data = next_rand();
            mask = next_rand();
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) data[8*b + 3 +: 2] = 2'b01;
            end
            write_csr(5'(w), data);
        end
        for (int k = 0; k < N_REGIONS; k++) begin
            step = next_rand();
            // An occasional step down makes later regions overlap earlier ones
            if (step[15:13] == 3'b000) begin
                top = top >> 1;
            end else begin
                top = top + (step & 32'h3ff);
            end
            write_csr(5'(k + 4), top);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and response monitor
    //////////////////////////////////////////////////////////////////////

    task automatic run_stimulus(input bit hold);
        bit          pending;
        int          stall;
        logic [31:0] r;
        pending   = 1'b0;
        stall     = 0;
        hold_free = hold;
        while (stim_q.size() > 0 || pending) begin
            @(negedge clk);
            r = next_rand();
            i_resp_free = hold || r[0];
            if (!pending) begin
                if (stim_q.size() > 0 && (hold || r[2:1] != 2'b00)) begin
                    i_req       = stim_q.pop_front();
                    i_req_drive = 1'b1;
                    pending     = 1'b1;
                end else begin
                    i_req_drive = 1'b0;
                end
            end
            @(posedge clk);
            if (pending && o_req_free) begin
                pending = 1'b0;
                stall   = 0;
            end else if (pending) begin
                stall++;
                assert (stall < 200) else fail_now("request not accepted within 200 cycles");
            end
        end
        @(negedge clk);
        i_req_drive = 1'b0;
        i_resp_free = 1'b1;
        stall = 0;
        while (exp_q.size() > 0) begin
            @(negedge clk);
            stall++;
            assert (stall < 50) else fail_now("pipeline did not drain within 50 cycles");
        end
        hold_free = 1'b0;
    endtask

    always @(posedge clk) begin
        pmp_resp_t exp_r;
        int        acc_c;
        cycle++;
        if (rstn) begin
            assert (dut_i.props_i.fail_count == 0)
                else fail_now("a bound property check failed");
            if (o_resp_drive && i_resp_free) begin
                assert (exp_q.size() > 0)
                    else fail_now("response transfer with no request outstanding");
                exp_r = exp_q.pop_front();
                acc_c = acc_q.pop_front();
                assert (o_resp == exp_r) else fail_now($sformatf(
                    "mismatch at %0t: o_resp got %h expected %h", $time, o_resp, exp_r));
                assert (cycle - acc_c >= 2)
                    else fail_now("response left less than two edges after acceptance");
                assert (!hold_free || cycle - acc_c == 2) else fail_now($sformatf(
                    "mismatch at %0t: latency got %0d expected 2", $time, cycle - acc_c));
            end
            if (i_req_drive && o_req_free) begin
                exp_q.push_back(expect_resp(i_req));
                acc_q.push_back(cycle);
            end
        end
    end

    initial begin
        rstn        = 1'b0;
        i_req_drive = 1'b0;
        i_req       = '0;
        i_resp_free = 1'b1;
        i_csr_we    = 1'b0;
        i_csr_sel   = '0;
        i_csr_wdata = '0;
        for (int k = 0; k < N_REGIONS; k++) begin
            cfg_m[k]  = '0;
            addr_m[k] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        assert (!o_resp_drive && o_req_free)
            else fail_now("after reset o_resp_drive is not low or o_req_free is not high");

        // R/W unlocked, OFF, locked X only, RWX unlocked
        write_csr(5'd0, 32'h0f8c070b);
        for (int k = 0; k < 4; k++) begin
            write_csr(5'(k + 4), 32'(k + 1) << 8);
        end
        for (int a = 0; a < 4; a++) begin
            stim_q.push_back(make_req(PRIV_M, 2'(a), 32'h040));
            stim_q.push_back(make_req(PRIV_S, 2'(a), 32'h080));
            stim_q.push_back(make_req(PRIV_M, 2'(a), 32'h280));
            stim_q.push_back(make_req(PRIV_U, 2'(a), 32'h180));
            stim_q.push_back(make_req(PRIV_U, 2'(a), 32'h500));
        end
        run_stimulus(1'b0);

        for (int set = 0; set < 6; set++) begin
            write_random_csrs();
            repeat (40) stim_q.push_back(random_req());
            run_stimulus(1'b0);
            repeat (20) stim_q.push_back(random_req());
            run_stimulus(1'b1);
        end

        if (dut_i.props_i.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            fail_now("a bound property check failed");
        end
    end

endmodule

`default_nettype wire

// File: sources.f
pmp_pkg.sv
mmu_pmp_req_pkg.sv
pmp_csr_regs.sv
pmp_region_match.sv
mmu_pmp_match_stage.sv
mmu_pmp_check_stage.sv
mmu_pmp_top.sv
mmu_pmp_properties.sv
tb_mmu_pmp.sv

// File: Bender.yml
package:
  name: mmu_pmp

sources:
  # Packages first, then the design from the leaves up
  - files:
      - pmp_pkg.sv
      - mmu_pmp_req_pkg.sv
      - pmp_csr_regs.sv
      - pmp_region_match.sv
      - mmu_pmp_match_stage.sv
      - mmu_pmp_check_stage.sv
      - mmu_pmp_top.sv

  # Verification sources
  - target: test
    files:
      - mmu_pmp_properties.sv
      - tb_mmu_pmp.sv
